/* all.f */
common/modbusPkg.sv
rtl/crc16.sv
rtl/regBuffer.sv
rx/requestParser.sv
tx/responseBuilder.sv
rtl/busMaster.sv
rtl/modbusSlave.sv
tb/wbMemory.sv
tb/modbusTb.sv

/* common/modbusPkg.sv */
// shared Modbus codes and types; quantity limits are per request, register words are 16 bits
package modbusPkg;

    typedef enum logic [7:0] {
        readHolding   = 8'h03,
        readInput     = 8'h04,
        writeMultiple = 8'h10
    } funcCode;

    typedef enum logic [7:0] {
        illegalFunction = 8'h01,
        illegalAddress  = 8'h02,
        illegalValue    = 8'h03
    } excCode;

    typedef logic [15:0] regWord;
    typedef logic [6:0] bufIndex; // write buffer holds 128 words

    localparam logic [15:0] maxReadQty = 16'd125;
    localparam logic [15:0] maxWriteQty = 16'd123;

    // reflected CRC-16, sent low byte first
    localparam logic [15:0] crcInit = 16'hFFFF;
    localparam logic [15:0] crcPoly = 16'hA001;

endpackage

/* rtl/busMaster.sv */
// one classic Wishbone cycle at a time; wordStart is ignored while a cycle is open
`timescale 1ns/1ps
module busMaster import modbusPkg::*; #(
    parameter int addrWidth = 24
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wordStart,
    input  logic                 wordWrite,
    input  logic [addrWidth-1:0] wordAddr,
    input  regWord               wordData,
    input  regWord               wbDatIn,
    input  logic                 wbAck,
    output logic                 wordDone,
    output regWord               wordRdData,
    output logic [addrWidth-1:0] wbAdr,
    output regWord               wbDatOut,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe
);
    assign wbStb = wbCyc; // no wait states on the master side

    always_ff @(posedge clk) begin
        if (rst) begin
            wbCyc <= 1'b0;
            wbWe <= 1'b0;
            wordDone <= 1'b0;
        end else begin
            wordDone <= 1'b0;
            if (wbCyc) begin
                if (wbAck) begin
                    wbCyc <= 1'b0;
                    wbWe <= 1'b0;
                    wordDone <= 1'b1;
                end
            end else if (wordStart) begin
                wbCyc <= 1'b1;
                wbWe <= wordWrite;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wordStart && !wbCyc) begin
            wbAdr <= wordAddr;
            wbDatOut <= wordData;
        end
        if (wbCyc && wbAck) begin
            wordRdData <= wbDatIn; // captured in the ack cycle
        end
    end

endmodule

/* rtl/crc16.sv */
// folds one byte per enabled clock; clear wins over enable and takes effect on the next edge
`timescale 1ns/1ps
module crc16 import modbusPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clear,
    input  logic        enable,
    input  logic [7:0]  dataIn,
    output logic [15:0] crc
);
    logic [15:0] nextCrc;

    // eight shift steps per byte, lsb first
    always_comb begin
        nextCrc = crc ^ {8'h00, dataIn};
        for (int i = 0; i < 8; i++) begin
            nextCrc = nextCrc[0] ? ((nextCrc >> 1) ^ crcPoly) : (nextCrc >> 1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            crc <= crcInit;
        end else if (enable) begin
            crc <= nextCrc;
        end
    end

endmodule

/* rtl/modbusSlave.sv */
// single clock domain; UART and FIFO handshakes must be synchronous to clk
`timescale 1ns/1ps
module modbusSlave import modbusPkg::*; #(
    parameter int                   addrWidth = 24,
    parameter logic [7:0]           stationAddress = 8'h37,
    parameter logic [addrWidth-1:0] holdingOffset = 'hA00000,
    parameter logic [addrWidth-1:0] inputOffset = 'hB00000,
    parameter int                   holdingCount = 32,
    parameter int                   inputCount = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           rxData,
    input  logic                 rxValid,
    input  logic                 parityError,
    input  logic                 silence,
    output logic                 rxAck,
    output logic [7:0]           txData,
    output logic                 txReq,
    input  logic                 txAck,
    output logic [addrWidth-1:0] wbAdr,
    output regWord               wbDatOut,
    input  regWord               wbDatIn,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    input  logic                 wbAck
);
    logic                 reqValid;
    funcCode              reqFunc;
    logic [15:0]          reqStart;
    logic [15:0]          reqQty;
    logic                 reqError;
    excCode               reqExc;
    logic                 busy;
    logic                 wrEn;
    bufIndex              wrIndex;
    regWord               wrData;
    bufIndex              rdIndex;
    regWord               rdData;
    logic                 wordStart;
    logic                 wordWrite;
    logic [addrWidth-1:0] wordAddr;
    regWord               wordData;
    logic                 wordDone;
    regWord               wordRdData;

    requestParser #(
        .stationAddress (stationAddress),
        .holdingCount   (holdingCount),
        .inputCount     (inputCount)
    ) parser (.*);

    responseBuilder #(
        .addrWidth      (addrWidth),
        .stationAddress (stationAddress),
        .holdingOffset  (holdingOffset),
        .inputOffset    (inputOffset)
    ) builder (.*);

    busMaster #(
        .addrWidth (addrWidth)
    ) master (.*);

    regBuffer writeBuf (.*); // write data waits here until the CRC passes

endmodule

/* rtl/regBuffer.sv */
// write data store; read data appears one clock after rdIndex, contents undefined after reset
`timescale 1ns/1ps
module regBuffer import modbusPkg::*; (
    input  logic    clk,
    input  logic    wrEn,
    input  bufIndex wrIndex,
    input  regWord  wrData,
    input  bufIndex rdIndex,
    output regWord  rdData
);
    regWord mem [128];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrIndex] <= wrData;
        end
        rdData <= mem[rdIndex]; // registered read port
    end

endmodule

/* rx/requestParser.sv */
// needs silence high between frames and idle cycles between rxValid pulses; drops frames while busy
`timescale 1ns/1ps
module requestParser import modbusPkg::*; #(
    parameter logic [7:0] stationAddress = 8'h37,
    parameter int         holdingCount = 32,
    parameter int         inputCount = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  rxData,
    input  logic        rxValid,
    input  logic        parityError,
    input  logic        silence,
    input  logic        busy,
    output logic        rxAck,
    output logic        reqValid,
    output funcCode     reqFunc,
    output logic [15:0] reqStart,
    output logic [15:0] reqQty,
    output logic        reqError,
    output excCode      reqExc,
    output logic        wrEn,
    output bufIndex     wrIndex,
    output regWord      wrData
);
    typedef enum logic [3:0] {
        pStation, pFunc, pAddrHi, pAddrLo, pQtyHi, pQtyLo, pByteCount,
        pDataHi, pDataLo, pCrcLo, pCrcHi, pWait
    } parseState;

    parseState   state;
    parseState   cur;
    logic [7:0]  funcByte;
    logic [7:0]  dataHi;
    logic [7:0]  crcLo;
    logic [15:0] start;
    logic [15:0] qty;
    logic [15:0] curQty;
    logic [16:0] rangeEnd;
    logic [15:0] crc;
    bufIndex     wordCount;
    logic        isWrite;
    logic        qtyOk;
    logic        rangeOk;
    logic        crcClear;
    logic        crcEnable;

    assign cur = silence ? pStation : state; // silence restarts the frame
    assign isWrite = (funcByte == writeMultiple);
    assign curQty = (cur == pQtyLo) ? {qty[15:8], rxData} : qty;
    assign qtyOk = (curQty != 16'd0) && (curQty <= (isWrite ? maxWriteQty : maxReadQty));
    assign rangeEnd = {1'b0, start} + {1'b0, curQty};
    assign rangeOk = rangeEnd <= ((funcByte == readInput) ? 17'(inputCount) : 17'(holdingCount));

    assign wrEn = rxValid && !parityError && (cur == pDataLo);
    assign wrIndex = wordCount;
    assign wrData = {dataHi, rxData};

    assign crcClear = !rxValid && (cur == pStation || cur == pWait);
    assign crcEnable = rxValid && !(cur inside {pCrcLo, pCrcHi, pWait});

    crc16 rxCrc (
        .clk    (clk),
        .rst    (rst),
        .clear  (crcClear),
        .enable (crcEnable),
        .dataIn (rxData),
        .crc    (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pStation;
            rxAck <= 1'b0;
            reqValid <= 1'b0;
        end else begin
            rxAck <= rxValid;
            reqValid <= 1'b0;
            if (!rxValid) begin
                state <= cur;
            end else if (parityError) begin
                state <= pWait;
            end else begin
                case (cur)
                    pStation: state <= (busy || rxData != stationAddress) ? pWait : pFunc;
                    pFunc: begin
                        funcByte <= rxData;
                        if (rxData inside {readHolding, readInput, writeMultiple}) begin
                            state <= pAddrHi;
                        end else begin
                            state <= pWait;
                            reqValid <= 1'b1;
                            reqError <= 1'b1;
                            reqExc <= illegalFunction;
                            reqFunc <= funcCode'(rxData);
                        end
                    end
                    pAddrHi: begin
                        start[15:8] <= rxData;
                        state <= pAddrLo;
                    end
                    pAddrLo: begin
                        start[7:0] <= rxData;
                        state <= pQtyHi;
                    end
                    pQtyHi: begin
                        qty[15:8] <= rxData;
                        state <= pQtyLo;
                    end
                    pQtyLo: begin
                        qty[7:0] <= rxData;
                        if (!qtyOk || (!isWrite && !rangeOk)) begin
                            state <= pWait;
                            reqValid <= 1'b1;
                            reqError <= 1'b1;
                            reqExc <= qtyOk ? illegalAddress : illegalValue;
                            reqFunc <= funcCode'(funcByte);
                        end else begin
                            state <= isWrite ? pByteCount : pCrcLo;
                        end
                    end
                    pByteCount: begin
                        wordCount <= '0;
                        if ({1'b0, rxData} != {qty[7:0], 1'b0} || !rangeOk) begin
                            state <= pWait;
                            reqValid <= 1'b1;
                            reqError <= 1'b1;
                            reqFunc <= funcCode'(funcByte);
                            // byte count mismatch outranks the range check
                            if ({1'b0, rxData} != {qty[7:0], 1'b0}) begin
                                reqExc <= illegalValue;
                            end else begin
                                reqExc <= illegalAddress;
                            end
                        end else begin
                            state <= pDataHi;
                        end
                    end
                    pDataHi: begin
                        dataHi <= rxData;
                        state <= pDataLo;
                    end
                    pDataLo: begin
                        wordCount <= wordCount + 1'b1;
                        state <= (wordCount == qty[6:0] - 7'd1) ? pCrcLo : pDataHi;
                    end
                    pCrcLo: begin
                        crcLo <= rxData;
                        state <= pCrcHi;
                    end
                    pCrcHi: begin
                        state <= pWait; // rest of the line is ignored until silence
                        if ({rxData, crcLo} == crc) begin
                            reqValid <= 1'b1;
                            reqError <= 1'b0;
                            reqFunc <= funcCode'(funcByte);
                            reqStart <= start;
                            reqQty <= qty;
                        end
                    end
                    default: state <= pWait;
                endcase
            end
        end
    end

endmodule

/* tb/modbusTb.sv */
// random Modbus RTU traffic checked against a register image model; station 0x37, 32 words per space
`timescale 1ns/1ps
module modbusTb;
    localparam logic [7:0] station = 8'h37;
    localparam int numReads = 12;
    localparam int numWrites = 8;
    localparam int numFrames = numReads + 2 * numWrites + 7 + 6 + 2;

    logic        clk;
    logic        rst;
    logic [7:0]  rxData;
    logic        rxValid;
    logic        parityError;
    logic        silence;
    logic        rxAck;
    logic [7:0]  txData;
    logic        txReq;
    logic        txAck;
    logic [23:0] wbAdr;
    logic [15:0] wbDatOut;
    logic [15:0] wbDatIn;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic        wbAck;
    logic        strayAccess;
    logic [15:0] image [64]; // model copy, holding 0..31 then input 32..63
    logic        lastValid;
    logic        lastAck;
    int          errors;
    int          errMark;
    int          testNum;
    int          passCount;
    int          failCount;

    modbusSlave #(
        .addrWidth      (24),
        .stationAddress (station),
        .holdingOffset  (24'hA00000),
        .inputOffset    (24'hB00000),
        .holdingCount   (32),
        .inputCount     (32)
    ) UUT (
        .clk(clk), .rst(rst), .rxData(rxData), .rxValid(rxValid),
        .parityError(parityError), .silence(silence), .rxAck(rxAck),
        .txData(txData), .txReq(txReq), .txAck(txAck),
        .wbAdr(wbAdr), .wbDatOut(wbDatOut), .wbDatIn(wbDatIn),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAck(wbAck)
    );

    wbMemory #(
        .addrWidth     (24),
        .holdingOffset (24'hA00000),
        .inputOffset   (24'hB00000)
    ) mem (
        .clk(clk), .rst(rst), .wbAdr(wbAdr), .wbDatOut(wbDatOut), .wbDatIn(wbDatIn),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAck(wbAck), .strayAccess(strayAccess)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        lastValid <= rxValid;
        lastAck <= wbAck;
    end

    // one rxAck for every rxValid, one cycle later
    always @(negedge clk) begin
        if (!rst) begin
            assert (rxAck === lastValid) else begin
                errors++;
                $display("** Error @ %0t: rxAck expected %b got %b", $time, lastValid, rxAck);
            end
            assert (wbStb === wbCyc) else begin // strobe rises and falls with the cycle
                errors++;
                $display("** Error @ %0t: wbStb expected %b got %b", $time, wbCyc, wbStb);
            end
            assert (!(lastAck && wbCyc)) else begin
                errors++;
                $display("** Error @ %0t: wbCyc expected 0 got %b after wbAck", $time, wbCyc);
            end
        end
    end

    function automatic logic [15:0] frameCrc(input logic [7:0] bytes [$]);
        logic [15:0] c;
        c = 16'hFFFF;
        foreach (bytes[i]) begin
            c = c ^ {8'h00, bytes[i]};
            repeat (8) begin
                c = c[0] ? ((c >> 1) ^ 16'hA001) : (c >> 1);
            end
        end
        return c;
    endfunction

    task automatic sendByte(input logic [7:0] b, input logic bad);
        @(negedge clk);
        rxData = b;
        rxValid = 1'b1;
        parityError = bad;
        @(negedge clk);
        rxValid = 1'b0;
        parityError = 1'b0;
    endtask

    task automatic sendFrame(input logic [7:0] body [$], input logic corruptCrc, input int parityAt);
        logic [15:0] crc;
        crc = frameCrc(body) ^ {15'd0, corruptCrc};
        body.push_back(crc[7:0]);
        body.push_back(crc[15:8]);
        @(negedge clk);
        silence = 1'b0;
        foreach (body[i]) begin
            sendByte(body[i], i == parityAt);
        end
        @(negedge clk);
        silence = 1'b1; // gap after the frame
    endtask

    task automatic expectSilent(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!txReq) else begin
                errors++;
                $display("unexpected txReq at %0t with no response due", $time);
            end
        end
    endtask

    task automatic expectResponse(input logic [7:0] body [$]);
        logic [15:0] crc;
        logic [7:0]  held;
        int          waited;
        crc = frameCrc(body);
        body.push_back(crc[7:0]);
        body.push_back(crc[15:8]);
        foreach (body[i]) begin
            waited = 0;
            while (!txReq && waited < 2000) begin
                @(negedge clk);
                waited++;
            end
            assert (txReq) else begin
                errors++;
                $display("response byte %0d never came within 2000 cycles at %0t", i, $time);
            end
            if (!txReq) return;
            held = txData;
            repeat ($urandom_range(4, 0)) @(negedge clk); // FIFO back-pressure
            assert (txReq && txData == held) else begin
                errors++;
                $display("** Error @ %0t: txData expected %02h got %02h", $time, held, txData);
            end
            assert (txData == body[i]) else begin
                errors++;
                $display("** Error @ %0t: txData byte %0d expected %02h got %02h",
                         $time, i, body[i], txData);
            end
            txAck = 1'b1;
            @(negedge clk);
            txAck = 1'b0;
        end
        expectSilent(4);
    endtask

    task automatic checkMemory;
        for (int i = 0; i < 64; i++) begin
            assert (mem.store[i] === image[i]) else begin
                errors++;
                $display("** Error @ %0t: memory word %0d expected %04h got %04h",
                         $time, i, image[i], mem.store[i]);
            end
        end
        assert (!strayAccess) else begin
            errors++;
            $display("Wishbone access outside both register spaces seen by %0t", $time);
        end
    endtask

    task automatic readTest(input logic [7:0] func, input int start, input int qty);
        logic [7:0] req [$];
        logic [7:0] rsp [$];
        int         base;
        base = (func == 8'h04) ? 32 : 0;
        req = '{station, func, 8'(start >> 8), 8'(start), 8'(qty >> 8), 8'(qty)};
        rsp = '{station, func, 8'(2 * qty)};
        for (int i = 0; i < qty; i++) begin
            rsp.push_back(image[base + start + i][15:8]);
            rsp.push_back(image[base + start + i][7:0]);
        end
        sendFrame(req, 1'b0, -1);
        expectResponse(rsp);
    endtask

    task automatic writeTest(input int start, input int qty, input logic corrupt);
        logic [7:0]  req [$];
        logic [15:0] data [$];
        logic [15:0] word;
        req = '{station, 8'h10, 8'(start >> 8), 8'(start), 8'(qty >> 8), 8'(qty), 8'(2 * qty)};
        for (int i = 0; i < qty; i++) begin
            word = 16'($urandom);
            data.push_back(word);
            req.push_back(word[15:8]);
            req.push_back(word[7:0]);
        end
        sendFrame(req, corrupt, -1);
        if (corrupt) begin
            expectSilent(60); // bad CRC must never reach the bus
        end else begin
            foreach (data[i]) begin
                image[start + i] = data[i];
            end
            expectResponse('{station, 8'h10, 8'(start >> 8), 8'(start), 8'(qty >> 8), 8'(qty)});
        end
        checkMemory();
    endtask

    task automatic excTest(input logic [7:0] req [$], input logic [7:0] code);
        sendFrame(req, 1'b0, -1);
        expectResponse('{station, req[1] | 8'h80, code});
        checkMemory();
    endtask

    task automatic finishTest(input string name);
        testNum++;
        if (errors == errMark) begin
            passCount++;
            $display("test %0d %s: ok", testNum, name);
        end else begin
            failCount++;
            $display("test %0d %s: failed with %0d errors", testNum, name, errors - errMark);
        end
        errMark = errors;
    endtask

    initial begin
        logic [7:0] req [$];
        logic [7:0] func;
        int         start;
        int         qty;
        void'($urandom(32'haa8baaaf));
        rst = 1'b1;
        rxData = 8'h00;
        rxValid = 1'b0;
        parityError = 1'b0;
        silence = 1'b1;
        txAck = 1'b0;
        errors = 0;
        errMark = 0;
        testNum = 0;
        passCount = 0;
        failCount = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 64; i++) begin
            image[i] = mem.store[i]; // starting image
        end

        for (int n = 0; n < numReads; n++) begin
            func = ($urandom_range(1, 0) != 0) ? 8'h04 : 8'h03;
            start = $urandom_range(31, 0);
            qty = $urandom_range(32 - start, 1);
            readTest(func, start, qty);
            finishTest("random read");
        end

        for (int n = 0; n < numWrites; n++) begin
            start = $urandom_range(31, 0);
            qty = $urandom_range(32 - start, 1);
            writeTest(start, qty, 1'b0);
            finishTest("random write");
            readTest(8'h03, start, qty);
            finishTest("read back");
        end

        req = '{station, 8'h06, 8'h00, 8'h00, 8'h00, 8'h01};
        excTest(req, 8'h01);
        finishTest("unsupported function");
        req = '{station, 8'h03, 8'h00, 8'h00, 8'h00, 8'h00};
        excTest(req, 8'h03);
        finishTest("read quantity zero");
        req = '{station, 8'h03, 8'h00, 8'h00, 8'h00, 8'd126};
        excTest(req, 8'h03);
        finishTest("read quantity over limit");
        req = '{station, 8'h10, 8'h00, 8'h00, 8'h00, 8'd124, 8'd248};
        excTest(req, 8'h03);
        finishTest("write quantity over limit");
        req = '{station, 8'h10, 8'h00, 8'h00, 8'h00, 8'h02, 8'h03, 8'h00, 8'h01, 8'h00, 8'h02};
        excTest(req, 8'h03);
        finishTest("byte count mismatch");
        req = '{station, 8'h04, 8'h00, 8'd30, 8'h00, 8'h03};
        excTest(req, 8'h02);
        finishTest("read out of range");
        req = '{station, 8'h10, 8'h00, 8'd31, 8'h00, 8'h02, 8'h04, 8'h12, 8'h34, 8'h56, 8'h78};
        excTest(req, 8'h02);
        finishTest("write out of range");

        // wrong station, bad CRC, parity error, each followed by a good frame
        for (int k = 0; k < 3; k++) begin
            req = '{station, 8'h03, 8'h00, 8'h02, 8'h00, 8'h05};
            if (k == 0) req[0] = 8'h38;
            sendFrame(req, k == 1, (k == 2) ? 3 : -1);
            expectSilent(60);
            finishTest("dropped frame");
            readTest(8'h03, 2, 5);
            finishTest("resync read");
        end
        writeTest(4, 6, 1'b1);
        finishTest("bad CRC write dropped");
        readTest(8'h03, 4, 6);
        finishTest("read after dropped write");

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 testNum, passCount, failCount, errors);
        if (errors == 0 && failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog sized by frame count
    initial begin
        repeat (numFrames * 2000) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not complete", numFrames * 2000);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* tb/wbMemory.sv */
// two 32-word register spaces filled with random words during reset; ack after 0 to 3 extra cycles
`timescale 1ns/1ps
module wbMemory import modbusPkg::*; #(
    parameter int                   addrWidth = 24,
    parameter logic [addrWidth-1:0] holdingOffset = 'hA00000,
    parameter logic [addrWidth-1:0] inputOffset = 'hB00000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [addrWidth-1:0] wbAdr,
    input  regWord               wbDatOut,
    output regWord               wbDatIn,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    output logic                 wbAck,
    output logic                 strayAccess
);
    regWord     store [64]; // holding words 0..31, input words 32..63
    logic       inHolding;
    logic       inInput;
    logic [5:0] index;
    logic       counting;
    int         waitLeft;

    assign inHolding = (wbAdr - holdingOffset) < addrWidth'(32);
    assign inInput = (wbAdr - inputOffset) < addrWidth'(32);
    assign index = inInput ? {1'b1, 5'(wbAdr - inputOffset)} : {1'b0, 5'(wbAdr - holdingOffset)};

    always @(posedge clk) begin
        if (rst) begin
            wbAck <= 1'b0;
            wbDatIn <= '0;
            counting <= 1'b0;
            strayAccess <= 1'b0;
            for (int i = 0; i < 64; i++) begin
                store[i] <= regWord'($urandom);
            end
        end else begin
            wbAck <= 1'b0;
            if (wbCyc && wbStb && !wbAck) begin
                if (!counting) begin
                    counting <= 1'b1;
                    waitLeft <= $urandom_range(3, 0);
                end else if (waitLeft > 0) begin
                    waitLeft <= waitLeft - 1;
                end else begin
                    counting <= 1'b0;
                    wbAck <= 1'b1;
                    if (!(inHolding || inInput)) begin
                        strayAccess <= 1'b1; // sticky until reset
                    end else if (wbWe) begin
                        store[index] <= wbDatOut;
                    end
                    wbDatIn <= store[index];
                end
            end
        end
    end

endmodule

/* tx/responseBuilder.sv */
// handles one request at a time; request fields must hold while busy, txData is valid with txReq
`timescale 1ns/1ps
module responseBuilder import modbusPkg::*; #(
    parameter int                   addrWidth = 24,
    parameter logic [7:0]           stationAddress = 8'h37,
    parameter logic [addrWidth-1:0] holdingOffset = 'hA00000,
    parameter logic [addrWidth-1:0] inputOffset = 'hB00000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 reqValid,
    input  funcCode              reqFunc,
    input  logic [15:0]          reqStart,
    input  logic [15:0]          reqQty,
    input  logic                 reqError,
    input  excCode               reqExc,
    input  logic                 txAck,
    input  logic                 wordDone,
    input  regWord               wordRdData,
    input  regWord               rdData,
    output logic                 busy,
    output logic [7:0]           txData,
    output logic                 txReq,
    output logic                 wordStart,
    output logic                 wordWrite,
    output logic [addrWidth-1:0] wordAddr,
    output regWord               wordData,
    output bufIndex              rdIndex
);
    typedef enum logic [4:0] {
        bIdle, bWrFetch, bWrIssue, bWrBus, bRdBus,
        bStation, bFunc, bExc, bCount, bAddrHi, bAddrLo, bQtyHi, bQtyLo,
        bDataHi, bDataLo, bCrcLo, bCrcHi
    } buildState;

    buildState            state;
    bufIndex              wordIdx;
    regWord               rdWord;
    logic [15:0]          crc;
    logic [addrWidth-1:0] baseAddr;
    logic [addrWidth-1:0] issueAddr;
    logic                 isWrite;
    logic                 lastWord;

    assign isWrite = (reqFunc == writeMultiple);
    assign lastWord = (wordIdx == reqQty[6:0]);
    assign baseAddr = (reqFunc == readInput) ? inputOffset : holdingOffset;
    assign issueAddr = baseAddr + addrWidth'(reqStart) + addrWidth'(wordIdx);
    assign rdIndex = wordIdx; // already advanced while the previous write runs
    assign busy = (state != bIdle);
    assign txReq = !(state inside {bIdle, bWrFetch, bWrIssue, bWrBus, bRdBus});

    always_comb begin
        case (state)
            bStation: txData = stationAddress;
            bFunc:    txData = reqError ? {1'b1, reqFunc[6:0]} : reqFunc;
            bExc:     txData = reqExc;
            bCount:   txData = {reqQty[6:0], 1'b0};
            bAddrHi:  txData = reqStart[15:8];
            bAddrLo:  txData = reqStart[7:0];
            bQtyHi:   txData = reqQty[15:8];
            bQtyLo:   txData = reqQty[7:0];
            bDataHi:  txData = rdWord[15:8];
            bDataLo:  txData = rdWord[7:0];
            bCrcLo:   txData = crc[7:0];
            bCrcHi:   txData = crc[15:8];
            default:  txData = 8'h00;
        endcase
    end

    // each byte is folded as the FIFO takes it
    crc16 txCrc (
        .clk    (clk),
        .rst    (rst),
        .clear  (state == bIdle),
        .enable (txReq && txAck && !(state inside {bCrcLo, bCrcHi})),
        .dataIn (txData),
        .crc    (crc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= bIdle;
            wordStart <= 1'b0;
        end else begin
            wordStart <= 1'b0;
            case (state)
                bIdle: begin
                    wordIdx <= '0;
                    if (reqValid) begin
                        state <= (!reqError && isWrite) ? bWrFetch : bStation;
                    end
                end
                bWrFetch: state <= bWrIssue; // buffer read latency
                bWrIssue: begin
                    wordStart <= 1'b1;
                    wordWrite <= 1'b1;
                    wordAddr <= issueAddr;
                    wordData <= rdData;
                    wordIdx <= wordIdx + 1'b1;
                    state <= bWrBus;
                end
                bWrBus: begin
                    if (wordDone) begin
                        state <= lastWord ? bStation : bWrIssue;
                    end
                end
                bRdBus: begin
                    if (wordDone) begin
                        rdWord <= wordRdData;
                        state <= bDataHi;
                    end
                end
                default: begin
                    if (txAck) begin
                        case (state)
                            bStation: state <= bFunc;
                            bFunc:    state <= reqError ? bExc : (isWrite ? bAddrHi : bCount);
                            bAddrHi:  state <= bAddrLo;
                            bAddrLo:  state <= bQtyHi;
                            bQtyHi:   state <= bQtyLo;
                            bDataHi:  state <= bDataLo;
                            bExc, bQtyLo: state <= bCrcLo;
                            bCrcLo:   state <= bCrcHi;
                            bCrcHi:   state <= bIdle;
                            bCount, bDataLo: begin
                                if (state == bDataLo && lastWord) begin
                                    state <= bCrcLo;
                                end else begin
                                    wordStart <= 1'b1; // next read only after the ack
                                    wordWrite <= 1'b0;
                                    wordAddr <= issueAddr;
                                    wordIdx <= wordIdx + 1'b1;
                                    state <= bRdBus;
                                end
                            end
                            default: state <= bIdle;
                        endcase
                    end
                end
            endcase
        end
    end

endmodule
